/* src/axi_pkg.sv */
// AXI4 channel widths and packed payload structs
// shared by the interconnect RTL and its testbench
package axi_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	localparam int ID_W   = 4;
	localparam int STRB_W = DATA_W / 8;

	// read address request
	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [ADDR_W-1:0] addr;
		logic [7:0]        len;
		logic [2:0]        size;
		logic [1:0]        burst;
	} axi_ar_t;

	// write address request, same fields as AR
	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [ADDR_W-1:0] addr;
		logic [7:0]        len;
		logic [2:0]        size;
		logic [1:0]        burst;
	} axi_aw_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
		logic              last;
	} axi_w_t;

	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [DATA_W-1:0] data;
		logic [1:0]        resp;
		logic              last;
	} axi_r_t;

	typedef struct packed {
		logic [ID_W-1:0] id;
		logic [1:0]      resp;
	} axi_b_t;

endpackage

/* src/soc_map_pkg.sv */
// SoC address map for the interconnect
// an address is seen flat by memory or as page plus register offset by the decoder
package soc_map_pkg;

	import axi_pkg::*;

	localparam int PAGE_W = 20;
	localparam int OFFS_W = ADDR_W - PAGE_W;

	// timer registers live in one 4 KiB page
	localparam logic [PAGE_W-1:0] DEFAULT_TIMER_PAGE = 20'h02004;

	// one bus address, two decodings
	typedef union packed {
		logic [ADDR_W-1:0] flat;
		struct packed {
			logic [PAGE_W-1:0] page;
			logic [OFFS_W-1:0] offset;
		} paged;
	} soc_addr_u;

endpackage

/* src/fetch_port.sv */
`timescale 1ns/1ps
// request slot for the read-only instruction fetch manager
// accepts one AR while empty and holds it until the router grants it
module fetch_port (
	input  logic             clk,
	input  logic             rst_n,
	input  axi_pkg::axi_ar_t ar,
	input  logic             arvalid,
	output logic             arready,
	input  logic             grant,
	output logic             req,
	output axi_pkg::axi_ar_t req_ar
);

	import axi_pkg::*;

	logic    full;
	logic    ar_accept;
	axi_ar_t slot_ar;

	assign ar_accept = arvalid && arready;
	assign arready   = ~full;
	assign req       = full;
	assign req_ar    = slot_ar;

	// slot occupancy
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			full <= 1'b0;
		end else if (ar_accept) begin
			full <= 1'b1;
		end else if (grant) begin
			full <= 1'b0;
		end
	end

	// capture the request on accept
	always_ff @(posedge clk) begin
		if (ar_accept) begin
			slot_ar <= ar;
		end
	end

endmodule

/* src/data_port.sv */
`timescale 1ns/1ps
// request slots for the data manager
// one read slot and one write slot, each filled on its address
// transfer and emptied when the router grants it
module data_port (
	input  logic             clk,
	input  logic             rst_n,
	input  axi_pkg::axi_ar_t ar,
	input  logic             arvalid,
	output logic             arready,
	input  axi_pkg::axi_aw_t aw,
	input  logic             awvalid,
	output logic             awready,
	input  logic             rd_grant,
	input  logic             wr_grant,
	output logic             rd_req,
	output axi_pkg::axi_ar_t req_ar,
	output logic             wr_req,
	output axi_pkg::axi_aw_t req_aw
);

	import axi_pkg::*;

	logic    rd_full;
	logic    wr_full;
	logic    ar_accept;
	logic    aw_accept;
	axi_ar_t rd_slot;
	axi_aw_t wr_slot;

	assign ar_accept = arvalid && arready;
	assign aw_accept = awvalid && awready;

	assign arready = ~rd_full;
	assign awready = ~wr_full;
	assign rd_req  = rd_full;
	assign wr_req  = wr_full;
	assign req_ar  = rd_slot;
	assign req_aw  = wr_slot;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_full <= 1'b0;
			wr_full <= 1'b0;
		end else begin
			if (ar_accept) begin
				rd_full <= 1'b1;
			end else if (rd_grant) begin
				rd_full <= 1'b0;
			end
			// write slot runs independently of the read slot
			if (aw_accept) begin
				wr_full <= 1'b1;
			end else if (wr_grant) begin
				wr_full <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ar_accept) begin
			rd_slot <= ar;
		end
		if (aw_accept) begin
			wr_slot <= aw;
		end
	end

endmodule

/* src/slave_router.sv */
`timescale 1ns/1ps
// routes held manager requests to main memory or the timer block
// one read and one write may be in flight, data reads win over fetch reads
// R, W and B pass combinationally between owner and target
module slave_router #(
	parameter logic [soc_map_pkg::PAGE_W-1:0] TIMER_PAGE = soc_map_pkg::DEFAULT_TIMER_PAGE
) (
	input  logic             clk,
	input  logic             rst_n,
	// manager side
	input  logic             fetch_req,
	input  axi_pkg::axi_ar_t fetch_ar,
	output logic             fetch_grant,
	input  logic             data_rd_req,
	input  axi_pkg::axi_ar_t data_ar,
	output logic             data_rd_grant,
	input  logic             data_wr_req,
	input  axi_pkg::axi_aw_t data_aw,
	output logic             data_wr_grant,
	input  axi_pkg::axi_w_t  data_w,
	input  logic             data_wvalid,
	output logic             data_wready,
	output axi_pkg::axi_r_t  fetch_r,
	output logic             fetch_rvalid,
	input  logic             fetch_rready,
	output axi_pkg::axi_r_t  data_r,
	output logic             data_rvalid,
	input  logic             data_rready,
	output axi_pkg::axi_b_t  data_b,
	output logic             data_bvalid,
	input  logic             data_bready,
	// main memory
	output axi_pkg::axi_ar_t mem_ar,
	output logic             mem_arvalid,
	input  logic             mem_arready,
	output axi_pkg::axi_aw_t mem_aw,
	output logic             mem_awvalid,
	input  logic             mem_awready,
	output axi_pkg::axi_w_t  mem_w,
	output logic             mem_wvalid,
	input  logic             mem_wready,
	input  axi_pkg::axi_r_t  mem_r,
	input  logic             mem_rvalid,
	output logic             mem_rready,
	input  axi_pkg::axi_b_t  mem_b,
	input  logic             mem_bvalid,
	output logic             mem_bready,
	// timer block
	output axi_pkg::axi_ar_t timer_ar,
	output logic             timer_arvalid,
	input  logic             timer_arready,
	output axi_pkg::axi_aw_t timer_aw,
	output logic             timer_awvalid,
	input  logic             timer_awready,
	output axi_pkg::axi_w_t  timer_w,
	output logic             timer_wvalid,
	input  logic             timer_wready,
	input  axi_pkg::axi_r_t  timer_r,
	input  logic             timer_rvalid,
	output logic             timer_rready,
	input  axi_pkg::axi_b_t  timer_b,
	input  logic             timer_bvalid,
	output logic             timer_bready
);

	import axi_pkg::*;
	import soc_map_pkg::*;

	localparam logic [1:0] RD_IDLE = 2'd0;
	localparam logic [1:0] RD_ADDR = 2'd1;
	localparam logic [1:0] RD_DATA = 2'd2;

	// page compare through the paged view of the address
	function automatic logic hits_timer(input logic [ADDR_W-1:0] addr);
		soc_addr_u a;
		a.flat = addr;
		return a.paged.page == TIMER_PAGE;
	endfunction

	logic [1:0] rd_state;
	logic       rd_owner_data;
	logic       rd_timer;
	logic       rd_pick_data;
	logic       rd_present;
	logic       rd_to_timer;
	logic       ar_hs;
	axi_ar_t    rd_ar;
	axi_r_t     sub_r;
	logic       sub_rvalid;
	logic       owner_rready;
	logic       r_last_hs;
	logic       wr_busy;
	logic       wr_timer;
	logic       aw_to_timer;
	logic       aw_hs;
	logic       b_hs;

	// priority choice only while idle, then locked until AR is taken
	assign rd_pick_data = (rd_state == RD_IDLE) ? data_rd_req : rd_owner_data;
	assign rd_ar        = rd_pick_data ? data_ar : fetch_ar;
	assign rd_present   = (rd_state == RD_ADDR) ||
	                      (rd_state == RD_IDLE && (data_rd_req || fetch_req));
	assign rd_to_timer  = hits_timer(rd_ar.addr);
	assign ar_hs        = rd_present && (rd_to_timer ? timer_arready : mem_arready);

	assign mem_ar        = rd_ar;
	assign timer_ar      = rd_ar;
	assign mem_arvalid   = rd_present && !rd_to_timer;
	assign timer_arvalid = rd_present && rd_to_timer;
	assign data_rd_grant = ar_hs && rd_pick_data;
	assign fetch_grant   = ar_hs && !rd_pick_data;

	// R beats from the recorded target to the recorded owner
	assign sub_r        = rd_timer ? timer_r : mem_r;
	assign sub_rvalid   = (rd_state == RD_DATA) && (rd_timer ? timer_rvalid : mem_rvalid);
	assign owner_rready = rd_owner_data ? data_rready : fetch_rready;
	assign fetch_r      = sub_r;
	assign data_r       = sub_r;
	assign fetch_rvalid = sub_rvalid && !rd_owner_data;
	assign data_rvalid  = sub_rvalid && rd_owner_data;
	assign mem_rready   = (rd_state == RD_DATA) && !rd_timer && owner_rready;
	assign timer_rready = (rd_state == RD_DATA) && rd_timer && owner_rready;
	assign r_last_hs    = sub_rvalid && owner_rready && sub_r.last;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_state      <= RD_IDLE;
			rd_owner_data <= 1'b0;
			rd_timer      <= 1'b0;
		end else begin
			case (rd_state)
				RD_IDLE: begin
					if (rd_present) begin
						rd_owner_data <= rd_pick_data;
						rd_timer      <= rd_to_timer;
						rd_state      <= ar_hs ? RD_DATA : RD_ADDR;
					end
				end
				RD_ADDR: begin
					if (ar_hs) begin
						rd_state <= RD_DATA;
					end
				end
				RD_DATA: begin
					if (r_last_hs) begin
						rd_state <= RD_IDLE;
					end
				end
				default: rd_state <= RD_IDLE;
			endcase
		end
	end

	// write path, data manager only
	assign aw_to_timer   = hits_timer(data_aw.addr);
	assign mem_aw        = data_aw;
	assign timer_aw      = data_aw;
	assign mem_awvalid   = !wr_busy && data_wr_req && !aw_to_timer;
	assign timer_awvalid = !wr_busy && data_wr_req && aw_to_timer;
	assign aw_hs         = (mem_awvalid && mem_awready) || (timer_awvalid && timer_awready);
	assign data_wr_grant = aw_hs;

	// W only flows once the AW has been taken by its target
	assign mem_w        = data_w;
	assign timer_w      = data_w;
	assign mem_wvalid   = wr_busy && !wr_timer && data_wvalid;
	assign timer_wvalid = wr_busy && wr_timer && data_wvalid;
	assign data_wready  = wr_busy && (wr_timer ? timer_wready : mem_wready);

	assign data_b       = wr_timer ? timer_b : mem_b;
	assign data_bvalid  = wr_busy && (wr_timer ? timer_bvalid : mem_bvalid);
	assign mem_bready   = wr_busy && !wr_timer && data_bready;
	assign timer_bready = wr_busy && wr_timer && data_bready;
	assign b_hs         = data_bvalid && data_bready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_busy  <= 1'b0;
			wr_timer <= 1'b0;
		end else if (aw_hs) begin
			wr_busy  <= 1'b1;
			wr_timer <= aw_to_timer;
		end else if (b_hs) begin
			wr_busy <= 1'b0;
		end
	end

endmodule

/* src/axi_interconnect.sv */
`timescale 1ns/1ps
// AXI crossbar top: fetch and data managers onto memory and timer
// the timer page is set here and handed to the router
module axi_interconnect #(
	parameter logic [soc_map_pkg::PAGE_W-1:0] TIMER_PAGE = soc_map_pkg::DEFAULT_TIMER_PAGE
) (
	input  logic             clk,
	input  logic             rst_n,
	// instruction fetch manager
	input  axi_pkg::axi_ar_t fetch_ar,
	input  logic             fetch_arvalid,
	output logic             fetch_arready,
	output axi_pkg::axi_r_t  fetch_r,
	output logic             fetch_rvalid,
	input  logic             fetch_rready,
	// data manager
	input  axi_pkg::axi_ar_t data_ar,
	input  logic             data_arvalid,
	output logic             data_arready,
	output axi_pkg::axi_r_t  data_r,
	output logic             data_rvalid,
	input  logic             data_rready,
	input  axi_pkg::axi_aw_t data_aw,
	input  logic             data_awvalid,
	output logic             data_awready,
	input  axi_pkg::axi_w_t  data_w,
	input  logic             data_wvalid,
	output logic             data_wready,
	output axi_pkg::axi_b_t  data_b,
	output logic             data_bvalid,
	input  logic             data_bready,
	// main memory
	output axi_pkg::axi_ar_t mem_ar,
	output logic             mem_arvalid,
	input  logic             mem_arready,
	output axi_pkg::axi_aw_t mem_aw,
	output logic             mem_awvalid,
	input  logic             mem_awready,
	output axi_pkg::axi_w_t  mem_w,
	output logic             mem_wvalid,
	input  logic             mem_wready,
	input  axi_pkg::axi_r_t  mem_r,
	input  logic             mem_rvalid,
	output logic             mem_rready,
	input  axi_pkg::axi_b_t  mem_b,
	input  logic             mem_bvalid,
	output logic             mem_bready,
	// timer block
	output axi_pkg::axi_ar_t timer_ar,
	output logic             timer_arvalid,
	input  logic             timer_arready,
	output axi_pkg::axi_aw_t timer_aw,
	output logic             timer_awvalid,
	input  logic             timer_awready,
	output axi_pkg::axi_w_t  timer_w,
	output logic             timer_wvalid,
	input  logic             timer_wready,
	input  axi_pkg::axi_r_t  timer_r,
	input  logic             timer_rvalid,
	output logic             timer_rready,
	input  axi_pkg::axi_b_t  timer_b,
	input  logic             timer_bvalid,
	output logic             timer_bready
);

	import axi_pkg::*;

	// held requests between the ports and the router
	logic    fetch_req;
	logic    fetch_grant;
	axi_ar_t fetch_req_ar;
	logic    data_rd_req;
	logic    data_rd_grant;
	axi_ar_t data_req_ar;
	logic    data_wr_req;
	logic    data_wr_grant;
	axi_aw_t data_req_aw;

	fetch_port fetch_port_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.ar      (fetch_ar),
		.arvalid (fetch_arvalid),
		.arready (fetch_arready),
		.grant   (fetch_grant),
		.req     (fetch_req),
		.req_ar  (fetch_req_ar)
	);

	data_port data_port_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.ar       (data_ar),
		.arvalid  (data_arvalid),
		.arready  (data_arready),
		.aw       (data_aw),
		.awvalid  (data_awvalid),
		.awready  (data_awready),
		.rd_grant (data_rd_grant),
		.wr_grant (data_wr_grant),
		.rd_req   (data_rd_req),
		.req_ar   (data_req_ar),
		.wr_req   (data_wr_req),
		.req_aw   (data_req_aw)
	);

	// remaining router ports share their names with the top level
	slave_router #(
		.TIMER_PAGE (TIMER_PAGE)
	) slave_router_inst (
		.fetch_ar (fetch_req_ar),
		.data_ar  (data_req_ar),
		.data_aw  (data_req_aw),
		.*
	);

endmodule

/* verif/axi_interconnect_assertions.sv */
`timescale 1ns/1ps
// protocol checks bound onto the interconnect top level
module axi_interconnect_assertions (
	input logic             clk,
	input logic             rst_n,
	input axi_pkg::axi_ar_t mem_ar,
	input logic             mem_arvalid,
	input logic             mem_arready,
	input axi_pkg::axi_ar_t timer_ar,
	input logic             timer_arvalid,
	input logic             timer_arready,
	input axi_pkg::axi_aw_t mem_aw,
	input logic             mem_awvalid,
	input logic             mem_awready,
	input logic             fetch_rvalid,
	input logic             data_rvalid
);

	// held valid keeps its payload until taken
	a_mem_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
		mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_ar))
		else $error("mem AR dropped or changed before ready");

	a_timer_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
		timer_arvalid && !timer_arready |=> timer_arvalid && $stable(timer_ar))
		else $error("timer AR dropped or changed before ready");

	a_mem_aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
		mem_awvalid && !mem_awready |=> mem_awvalid && $stable(mem_aw))
		else $error("mem AW dropped or changed before ready");

	a_one_ar_target: assert property (@(posedge clk) !(mem_arvalid && timer_arvalid))
		else $error("AR sent to both subordinates");

	a_r_idle_after_reset: assert property (@(posedge clk)
		!rst_n |=> !fetch_rvalid && !data_rvalid)
		else $error("rvalid high right after reset");

endmodule

bind axi_interconnect axi_interconnect_assertions axi_interconnect_assertions_inst (.*);

/* verif/tb_axi_interconnect.sv */
`timescale 1ns/1ps
// testbench for the AXI interconnect
// replays verif/axi_golden.txt through the fetch and data managers,
// models memory and timer as subordinates and checks every channel

// subordinate with random ready delays, returns rdata + beat on reads
module axi_sub_model (
	input  logic             clk,
	input  logic             rst_n,
	input  axi_pkg::axi_ar_t ar,
	input  logic             arvalid,
	output logic             arready,
	input  axi_pkg::axi_aw_t aw,
	input  logic             awvalid,
	output logic             awready,
	input  axi_pkg::axi_w_t  w,
	input  logic             wvalid,
	output logic             wready,
	output axi_pkg::axi_r_t  r,
	output logic             rvalid,
	input  logic             rready,
	output axi_pkg::axi_b_t  b,
	output logic             bvalid,
	input  logic             bready,
	input  logic [63:0]      rdata,
	input  logic             slow
);

	import axi_pkg::*;

	int         cycle;
	int         beat;
	int         ar_count;
	int         aw_count;
	int         w_count;
	int         ar_cycle;
	logic [7:0] rlen;
	logic       rd_busy;
	logic       wr_busy;
	axi_ar_t    last_ar;
	axi_aw_t    last_aw;
	axi_w_t     last_w;

	// read side, one burst at a time
	always @(posedge clk) begin
		if (!rst_n) begin
			cycle    <= 0;
			arready  <= 1'b0;
			rvalid   <= 1'b0;
			rd_busy  <= 1'b0;
			ar_count <= 0;
		end else begin
			cycle <= cycle + 1;
			if (arvalid && arready) begin
				arready  <= 1'b0;
				rd_busy  <= 1'b1;
				last_ar  <= ar;
				ar_count <= ar_count + 1;
				ar_cycle <= cycle;
				rlen     <= ar.len;
				beat     <= 0;
				r.id     <= ar.id;
				r.data   <= rdata;
				r.resp   <= 2'b00;
				r.last   <= (ar.len == 8'd0);
				rvalid   <= 1'b1;
			end else if (arvalid && !rd_busy) begin
				arready <= ($urandom % 3) == 0;
			end
			if (rvalid && rready) begin
				if (r.last) begin
					rvalid  <= 1'b0;
					rd_busy <= 1'b0;
				end else begin
					beat   <= beat + 1;
					r.data <= rdata + 64'(beat + 1);
					r.last <= (beat + 1 == int'(rlen));
				end
			end
		end
	end

	// write side, slow mode makes wready rare
	always @(posedge clk) begin
		if (!rst_n) begin
			awready  <= 1'b0;
			wready   <= 1'b0;
			bvalid   <= 1'b0;
			wr_busy  <= 1'b0;
			aw_count <= 0;
			w_count  <= 0;
		end else begin
			if (awvalid && awready) begin
				awready  <= 1'b0;
				wr_busy  <= 1'b1;
				last_aw  <= aw;
				aw_count <= aw_count + 1;
			end else if (awvalid && !wr_busy) begin
				awready <= ($urandom % 3) == 0;
			end
			if (wvalid && wready) begin
				wready  <= 1'b0;
				last_w  <= w;
				w_count <= w_count + 1;
				if (w.last) begin
					b.id   <= last_aw.id;
					b.resp <= 2'b00;
					bvalid <= 1'b1;
				end
			end else if (wvalid && !bvalid) begin
				wready <= slow ? (($urandom % 8) == 0) : (($urandom % 2) == 0);
			end
			if (bvalid && bready) begin
				bvalid  <= 1'b0;
				wr_busy <= 1'b0;
			end
		end
	end

endmodule

module tb_axi_interconnect;

	import axi_pkg::*;
	import soc_map_pkg::*;

	localparam int TIMEOUT = 400;
	localparam int MAX_LINES = 16;

	logic    clk;
	logic    rst_n;
	axi_ar_t fetch_ar;
	logic    fetch_arvalid;
	logic    fetch_arready;
	axi_r_t  fetch_r;
	logic    fetch_rvalid;
	logic    fetch_rready;
	axi_ar_t data_ar;
	logic    data_arvalid;
	logic    data_arready;
	axi_r_t  data_r;
	logic    data_rvalid;
	logic    data_rready;
	axi_aw_t data_aw;
	logic    data_awvalid;
	logic    data_awready;
	axi_w_t  data_w;
	logic    data_wvalid;
	logic    data_wready;
	axi_b_t  data_b;
	logic    data_bvalid;
	logic    data_bready;
	axi_ar_t mem_ar;
	axi_ar_t timer_ar;
	axi_aw_t mem_aw;
	axi_aw_t timer_aw;
	axi_w_t  mem_w;
	axi_w_t  timer_w;
	axi_r_t  mem_r;
	axi_r_t  timer_r;
	axi_b_t  mem_b;
	axi_b_t  timer_b;
	logic    mem_arvalid;
	logic    mem_arready;
	logic    mem_awvalid;
	logic    mem_awready;
	logic    mem_wvalid;
	logic    mem_wready;
	logic    mem_rvalid;
	logic    mem_rready;
	logic    mem_bvalid;
	logic    mem_bready;
	logic    timer_arvalid;
	logic    timer_arready;
	logic    timer_awvalid;
	logic    timer_awready;
	logic    timer_wvalid;
	logic    timer_wready;
	logic    timer_rvalid;
	logic    timer_rready;
	logic    timer_bvalid;
	logic    timer_bready;
	logic [63:0] mem_rdata;
	logic [63:0] timer_rdata;
	logic        mem_slow;
	logic        timer_slow;

	// golden columns
	int          g_test[MAX_LINES];
	int          g_grp[MAX_LINES];
	logic        g_op[MAX_LINES];
	logic        g_mgr[MAX_LINES];
	logic [31:0] g_addr[MAX_LINES];
	logic [7:0]  g_len[MAX_LINES];
	logic [63:0] g_wdata[MAX_LINES];
	logic        g_tgt[MAX_LINES];
	logic [63:0] g_rdata[MAX_LINES];
	logic        g_stall[MAX_LINES];
	int          n_lines;
	int          errors;
	int          tests_run;
	int          tests_failed;

	axi_interconnect axi_interconnect_inst (.*);

	axi_sub_model mem_model (
		.clk (clk), .rst_n (rst_n),
		.ar (mem_ar), .arvalid (mem_arvalid), .arready (mem_arready),
		.aw (mem_aw), .awvalid (mem_awvalid), .awready (mem_awready),
		.w (mem_w), .wvalid (mem_wvalid), .wready (mem_wready),
		.r (mem_r), .rvalid (mem_rvalid), .rready (mem_rready),
		.b (mem_b), .bvalid (mem_bvalid), .bready (mem_bready),
		.rdata (mem_rdata), .slow (mem_slow)
	);

	axi_sub_model timer_model (
		.clk (clk), .rst_n (rst_n),
		.ar (timer_ar), .arvalid (timer_arvalid), .arready (timer_arready),
		.aw (timer_aw), .awvalid (timer_awvalid), .awready (timer_awready),
		.w (timer_w), .wvalid (timer_wvalid), .wready (timer_wready),
		.r (timer_r), .rvalid (timer_rvalid), .rready (timer_rready),
		.b (timer_b), .bvalid (timer_bvalid), .bready (timer_bready),
		.rdata (timer_rdata), .slow (timer_slow)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_ar(input string name, input axi_ar_t got, input axi_ar_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h exp %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_aw(input string name, input axi_aw_t got, input axi_aw_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h exp %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_w(input string name, input axi_w_t got, input axi_w_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h exp %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_r(input string name, input axi_r_t got, input axi_r_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h exp %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_b(input string name, input axi_b_t got, input axi_b_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h exp %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %s got %h exp %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("ERR %s got %h exp %h", name, got, exp);
			errors++;
		end
	endtask

	function automatic axi_ar_t make_ar(input int k);
		axi_ar_t a;
		a.id    = k[3:0];
		a.addr  = g_addr[k];
		a.len   = g_len[k];
		a.size  = 3'd3;
		a.burst = 2'd1;
		return a;
	endfunction

	task automatic send_ar(input logic mgr, input axi_ar_t req, output bit ok);
		int t;
		if (mgr) begin
			data_ar      <= req;
			data_arvalid <= 1'b1;
		end else begin
			fetch_ar      <= req;
			fetch_arvalid <= 1'b1;
		end
		ok = 1'b0;
		for (t = 0; t < TIMEOUT && !ok; t++) begin
			@(posedge clk);
			ok = mgr ? (data_arvalid && data_arready) : (fetch_arvalid && fetch_arready);
		end
		if (mgr) begin
			data_arvalid <= 1'b0;
		end else begin
			fetch_arvalid <= 1'b0;
		end
	endtask

	task automatic send_aw(input axi_aw_t req, output bit ok);
		int t;
		data_aw      <= req;
		data_awvalid <= 1'b1;
		ok = 1'b0;
		for (t = 0; t < TIMEOUT && !ok; t++) begin
			@(posedge clk);
			ok = data_awvalid && data_awready;
		end
		data_awvalid <= 1'b0;
	endtask

	task automatic send_w(input int k, output bit ok);
		int beat;
		int t;
		axi_w_t exp;
		ok = 1'b1;
		for (beat = 0; beat <= int'(g_len[k]) && ok; beat++) begin
			exp.data = g_wdata[k] + 64'(beat);
			exp.strb = '1;
			exp.last = (beat == int'(g_len[k]));
			data_w      <= exp;
			data_wvalid <= 1'b1;
			ok = 1'b0;
			for (t = 0; t < TIMEOUT && !ok; t++) begin
				@(posedge clk);
				ok = data_wvalid && data_wready;
			end
			// every beat reaches the selected target unchanged
			if (ok) begin
				if (g_tgt[k]) begin
					check_w("timer_w", timer_w, exp);
				end else begin
					check_w("mem_w", mem_w, exp);
				end
			end
		end
		data_wvalid <= 1'b0;
	endtask

	task automatic wait_b(input logic [3:0] id, output bit ok);
		int t;
		axi_b_t exp;
		exp.id   = id;
		exp.resp = 2'b00;
		ok = 1'b0;
		for (t = 0; t < TIMEOUT && !ok; t++) begin
			@(posedge clk);
			ok = data_bvalid && data_bready;
		end
		if (ok) begin
			check_b("data_b", data_b, exp);
		end
	endtask

	// collects every beat of one burst and checks it in order
	task automatic recv_r(input logic mgr, input axi_ar_t req, input logic [63:0] base,
			output bit ok);
		int beat;
		int t;
		axi_r_t exp;
		beat = 0;
		for (t = 0; t < TIMEOUT && beat <= int'(req.len); t++) begin
			@(posedge clk);
			if (mgr ? data_rvalid : fetch_rvalid) begin
				exp.id   = req.id;
				exp.data = base + 64'(beat);
				exp.resp = 2'b00;
				exp.last = (beat == int'(req.len));
				if (mgr) begin
					check_r("data_r", data_r, exp);
				end else begin
					check_r("fetch_r", fetch_r, exp);
				end
				beat++;
			end
		end
		ok = beat > int'(req.len);
	endtask

	task automatic run_line(input int k);
		axi_ar_t ar;
		bit ok;
		ar = make_ar(k);
		if (g_op[k]) begin
			send_aw(axi_aw_t'(ar), ok);
			if (ok) send_w(k, ok);
			if (ok) wait_b(ar.id, ok);
		end else begin
			send_ar(g_mgr[k], ar, ok);
			if (ok) recv_r(g_mgr[k], ar, g_rdata[k], ok);
		end
		if (!ok) begin
			$display("timeout on golden line %0d, the transaction never completed", k);
			errors++;
		end
	endtask

	// lines of one group start in the same cycle
	task automatic run_group(input int first, input int last);
		int c0[6];
		int ce[6];
		int fr;
		int dr;
		axi_w_t w_exp;
		fr = -1;
		dr = -1;
		ce = '{default: 0};
		c0 = '{mem_model.ar_count, timer_model.ar_count, mem_model.aw_count,
			timer_model.aw_count, mem_model.w_count, timer_model.w_count};
		@(posedge clk);
		for (int i = first; i <= last; i++) begin
			if (g_tgt[i]) begin
				timer_rdata <= g_rdata[i];
				timer_slow  <= g_stall[i];
			end else begin
				mem_rdata <= g_rdata[i];
				mem_slow  <= g_stall[i];
			end
			if (g_op[i]) begin
				ce[2 + int'(g_tgt[i])]++;
				ce[4 + int'(g_tgt[i])] += int'(g_len[i]) + 1;
			end else begin
				ce[int'(g_tgt[i])]++;
				if (g_mgr[i]) dr = i;
				else fr = i;
			end
		end
		for (int i = first; i <= last; i++) begin
			fork
				automatic int k = i;
				run_line(k);
			join_none
		end
		wait fork;
		check_count("mem_ar_count", mem_model.ar_count - c0[0], ce[0]);
		check_count("timer_ar_count", timer_model.ar_count - c0[1], ce[1]);
		check_count("mem_aw_count", mem_model.aw_count - c0[2], ce[2]);
		check_count("timer_aw_count", timer_model.aw_count - c0[3], ce[3]);
		check_count("mem_w_count", mem_model.w_count - c0[4], ce[4]);
		check_count("timer_w_count", timer_model.w_count - c0[5], ce[5]);
		for (int i = first; i <= last; i++) begin
			w_exp.data = g_wdata[i] + 64'(g_len[i]);
			w_exp.strb = '1;
			w_exp.last = 1'b1;
			if (g_op[i] && g_tgt[i]) begin
				check_aw("timer_aw", timer_model.last_aw, axi_aw_t'(make_ar(i)));
				check_w("timer_w", timer_model.last_w, w_exp);
			end else if (g_op[i]) begin
				check_aw("mem_aw", mem_model.last_aw, axi_aw_t'(make_ar(i)));
				check_w("mem_w", mem_model.last_w, w_exp);
			end else if (g_tgt[i]) begin
				check_ar("timer_ar", timer_model.last_ar, make_ar(i));
			end else begin
				check_ar("mem_ar", mem_model.last_ar, make_ar(i));
			end
		end
		// data read must reach its target before the fetch read
		if (fr >= 0 && dr >= 0) begin
			check_flag("data_ar_first",
				(g_tgt[dr] ? timer_model.ar_cycle : mem_model.ar_cycle) <
				(g_tgt[fr] ? timer_model.ar_cycle : mem_model.ar_cycle), 1'b1);
		end
	endtask

	task automatic load_golden();
		int fd;
		int cnt;
		string line;
		fd = $fopen("verif/axi_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open the golden file");
			errors++;
		end else begin
			while (!$feof(fd) && n_lines < MAX_LINES) begin
				line = "";
				cnt = $fgets(line, fd);
				if (line.len() > 1 && line[0] != "#") begin
					cnt = $sscanf(line, "%d %d %h %h %h %h %h %h %h %h",
						g_test[n_lines], g_grp[n_lines], g_op[n_lines], g_mgr[n_lines],
						g_addr[n_lines], g_len[n_lines], g_wdata[n_lines],
						g_tgt[n_lines], g_rdata[n_lines], g_stall[n_lines]);
					if (cnt == 10) n_lines++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic report_test(input int num, input int err0);
		tests_run++;
		if (errors == err0) begin
			$display("test %0d passed", num);
		end else begin
			tests_failed++;
			$display("test %0d failed", num);
		end
	endtask

	initial begin
		int i;
		int j;
		int err0;
		void'($urandom(32'h4122_4685));
		errors = 0;
		n_lines = 0;
		tests_run = 0;
		tests_failed = 0;
		rst_n = 1'b0;
		fetch_ar = '0;
		fetch_arvalid = 1'b0;
		fetch_rready = 1'b1;
		data_ar = '0;
		data_arvalid = 1'b0;
		data_rready = 1'b1;
		data_aw = '0;
		data_awvalid = 1'b0;
		data_w = '0;
		data_wvalid = 1'b0;
		data_bready = 1'b1;
		mem_rdata = '0;
		timer_rdata = '0;
		mem_slow = 1'b0;
		timer_slow = 1'b0;
		load_golden();
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		// idle state straight out of reset
		err0 = errors;
		check_flag("mem_arvalid", mem_arvalid, 1'b0);
		check_flag("timer_arvalid", timer_arvalid, 1'b0);
		check_flag("mem_awvalid", mem_awvalid, 1'b0);
		check_flag("timer_awvalid", timer_awvalid, 1'b0);
		check_flag("mem_wvalid", mem_wvalid, 1'b0);
		check_flag("timer_wvalid", timer_wvalid, 1'b0);
		check_flag("fetch_rvalid", fetch_rvalid, 1'b0);
		check_flag("data_rvalid", data_rvalid, 1'b0);
		check_flag("data_bvalid", data_bvalid, 1'b0);
		check_flag("fetch_arready", fetch_arready, 1'b1);
		check_flag("data_arready", data_arready, 1'b1);
		check_flag("data_awready", data_awready, 1'b1);
		report_test(1, err0);
		i = 0;
		while (i < n_lines) begin
			if (i == 0 || g_test[i] != g_test[i - 1]) err0 = errors;
			j = i;
			while (j + 1 < n_lines && g_grp[j + 1] == g_grp[i]) j++;
			run_group(i, j);
			if (j + 1 >= n_lines || g_test[j + 1] != g_test[i]) report_test(g_test[i], err0);
			i = j + 1;
		end
		$display("%0d tests run, %0d passed, %0d failed, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0 && tests_run == 6) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* verif/axi_golden.txt */
# test grp op(0 rd,1 wr) mgr(0 fetch,1 data) addr len wdata target(0 mem,1 timer) rdata stall
# lines sharing a grp start in the same cycle, all but test and grp are hex
2 1 1 1 00001000 01 1122334455667788 0 0000000000000000 0
3 2 1 1 02004008 00 00000000000f4240 1 0000000000000000 0
3 3 0 1 02004010 00 0000000000000000 1 00000000cafe0001 0
4 4 0 0 00002000 03 0000000000000000 0 a5a5000000000010 0
5 5 0 0 00003000 00 0000000000000000 0 0000000012345678 0
5 5 0 1 02004000 00 0000000000000000 1 0000000087654321 0
6 6 1 1 02004020 01 0bad0000beef0000 1 0000000000000000 1
6 6 0 0 00004000 01 0000000000000000 0 5a5a5a5a00000000 0

/* list.f */
src/axi_pkg.sv
src/soc_map_pkg.sv
src/fetch_port.sv
src/data_port.sv
src/slave_router.sv
src/axi_interconnect.sv
verif/axi_interconnect_assertions.sv
verif/tb_axi_interconnect.sv

/* run.sh */
#!/bin/sh
# build and run the interconnect testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal -f list.f --top-module tb_axi_interconnect -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "^TEST OK$"
